// File: cnode_unit.f
+incdir+hw
hw/cnode_unit_pkg.sv
hw/cnode_beat_if.sv
hw/cnode_pre_engine.sv
hw/cnode_min_search.sv
hw/cnode_msg_gen.sv
hw/cnode_unit.sv
tb/cnode_unit_tb.sv

// File: Bender.yml
package:
  name: cnode_unit

export_include_dirs:
  - hw

sources:
  # rtl
  - include_dirs:
      - hw
    files:
      - hw/cnode_unit_pkg.sv
      - hw/cnode_beat_if.sv
      - hw/cnode_pre_engine.sv
      - hw/cnode_min_search.sv
      - hw/cnode_msg_gen.sv
      - hw/cnode_unit.sv
  # testbench
  - target: test
    include_dirs:
      - hw
    files:
      - tb/cnode_unit_tb.sv

// File: tb/cnode_unit_tb.sv
// testbench for the check node unit with table rows and random rows checked against a min-sum model
`timescale 1ns/1ps
`include "cnode_unit_defines.svh"

module cnode_unit_tb
  import cnode_unit_pkg::*;
();

  localparam int N_TAB       = 11;
  localparam int N_RAND      = 40;
  localparam int N_ROWS      = N_TAB + N_RAND;
  // worst row is under 12 cycles with its idle and stall cycles
  localparam int TIMEOUT_CYC = N_ROWS * 12 + 200;

  // table row with input k in nibble k of vals and input 0 in the rightmost digit
  // stall bit b puts two clock-enable-low cycles before beat b
  typedef struct packed {
    logic [3:0]  deg;
    logic [3:0]  stall;
    logic        gap;
    logic [31:0] vals;
  } row_entry_t;

  logic                      iclk;
  logic                      ireset;
  logic                      iclkena;
  logic                      isop;
  logic                      ival;
  logic                      ieop;
  logic [`CNODE_LANES-1:0]   imask;
  node_t                     ivnode [`CNODE_LANES];
  logic                      orow_val;
  mag_t                      omin1;
  mag_t                      omin2;
  idx_t                      omin1_idx;
  logic                      oprod_sign;
  logic [`CNODE_MAX_DEG-1:0] ovn_sign;
  cnt_t                      ovn_cnt;
  logic                      omsg_val;
  msg_t                      omsg [`CNODE_LANES];
  logic                      omsg_last;

  row_entry_t  tab [N_TAB];
  cnode_res_t  exp_row_q [$];
  msg_t        exp_msg_q [$];
  logic        exp_last_q [$];
  int          eop_q [$];
  int          prev_beats;
  int          beats_exp;
  int          rows_seen;
  int          beats_seen;
  int          beat_in_row;
  int          ena_cnt;
  int          cycle_cnt;
  int unsigned seed_val;

  cnode_unit i_cnode_unit (
    .iclk       (iclk),
    .ireset     (ireset),
    .iclkena    (iclkena),
    .isop       (isop),
    .ival       (ival),
    .ieop       (ieop),
    .imask      (imask),
    .ivnode     (ivnode),
    .orow_val   (orow_val),
    .omin1      (omin1),
    .omin2      (omin2),
    .omin1_idx  (omin1_idx),
    .oprod_sign (oprod_sign),
    .ovn_sign   (ovn_sign),
    .ovn_cnt    (ovn_cnt),
    .omsg_val   (omsg_val),
    .omsg       (omsg),
    .omsg_last  (omsg_last)
  );

  always #10 iclk = ~iclk;

  // ----------------------------------------
  // failure reporting
  // ----------------------------------------

  task automatic stop_run();
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic report_mismatch(input string msg);
    $display("mismatch at %0t: %s", $time, msg);
    stop_run();
  endtask

  task automatic report_error(input string msg);
    $display("error at %0t: %s", $time, msg);
    stop_run();
  endtask

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------

  task automatic check_row(input cnode_res_t got, input cnode_res_t exp);
    if (got !== exp) begin
      report_mismatch($sformatf(
        "row %0d min1/min2/idx/ps/vs/cnt got %0d/%0d/%0d/%0b/%b/%0d exp %0d/%0d/%0d/%0b/%b/%0d",
        rows_seen, got.min1, got.min2, got.min1_idx, got.prod_sign, got.vn_sign, got.vn_cnt,
        exp.min1, exp.min2, exp.min1_idx, exp.prod_sign, exp.vn_sign, exp.vn_cnt));
    end
  endtask

  task automatic check_msg(input msg_t got, input msg_t exp, input int pos);
    if (got !== exp) begin
      report_mismatch($sformatf("row %0d message %0d got %0d expected %0d",
        rows_seen, pos, got, exp));
    end
  endtask

  task automatic check_last(input logic got, input logic exp);
    if (got !== exp) begin
      report_mismatch($sformatf("row %0d beat %0d omsg_last got %b expected %b",
        rows_seen, beat_in_row, got, exp));
    end
  endtask

  task automatic check_delay(input int got, input int exp);
    if (got != exp) begin
      report_mismatch($sformatf("orow_val %0d enabled cycles after ieop, expected %0d",
        got, exp));
    end
  endtask

  // ----------------------------------------
  // reference model
  // ----------------------------------------

  task automatic model_row(input int deg, input logic [31:0] vals);
    cnode_res_t r;
    int         mag [`CNODE_MAX_DEG];
    int         iv;
    int         m1;
    int         m2;
    int         m1_idx;
    int         cor;
    int         nbeats;
    r      = '0;
    m1     = 99;
    m1_idx = 0;
    // a missing second input leaves the all-ones code of an unused lane
    m2     = (1 << `CNODE_NODE_W) - 1;
    for (int k = 0; k < deg; k++) begin
      iv           = int'(node_t'(vals[4*k +: 4]));
      r.vn_sign[k] = (iv < 0);
      r.prod_sign  = r.prod_sign ^ (iv < 0);
      mag[k]       = (iv < 0) ? -iv : iv;
      // strict compare so ties stay on the earlier input
      if (mag[k] < m1) begin
        m1     = mag[k];
        m1_idx = k;
      end
    end
    for (int k = 0; k < deg; k++) begin
      if (k != m1_idx && mag[k] < m2) begin
        m2 = mag[k];
      end
    end
    r.min1     = mag_t'(m1);
    r.min2     = mag_t'(m2);
    r.min1_idx = idx_t'(m1_idx);
    r.vn_cnt   = cnt_t'(deg);
    exp_row_q.push_back(r);
    nbeats = (deg + 1) / 2;
    for (int k = 0; k < nbeats * `CNODE_LANES; k++) begin
      cor = 0;
      if (k < deg) begin
        cor = ((k == m1_idx) ? m2 : m1) - `CNODE_OFFSET;
        if (cor < 0) begin
          cor = 0;
        end
        if (r.prod_sign ^ r.vn_sign[k]) begin
          cor = -cor;
        end
      end
      exp_msg_q.push_back(msg_t'(cor));
    end
    for (int b = 0; b < nbeats; b++) begin
      exp_last_q.push_back(b == nbeats - 1);
      beats_exp++;
    end
  endtask

  // ----------------------------------------
  // stimulus for one row of beats
  // ----------------------------------------

  task automatic drive_row(input int deg, input logic [31:0] vals,
                           input logic [3:0] stall, input logic gap);
    int nbeats;
    int idle;
    nbeats = (deg + 1) / 2;
    idle   = int'(gap);
    // a short row after a long one waits until the messages are out
    if (prev_beats - nbeats > idle) begin
      idle = prev_beats - nbeats;
    end
    model_row(deg, vals);
    repeat (idle) begin
      @(negedge iclk);
      iclkena = 1'b1;
      ival    = 1'b0;
    end
    for (int b = 0; b < nbeats; b++) begin
      if (stall[b]) begin
        repeat (2) begin
          @(negedge iclk);
          iclkena = 1'b0;
          ival    = 1'b0;
        end
      end
      @(negedge iclk);
      iclkena   = 1'b1;
      ival      = 1'b1;
      isop      = (b == 0);
      ieop      = (b == nbeats - 1);
      // lane 1 of the last beat of an odd row is unused but still carries junk
      imask     = {logic'(2*b + 1 < deg), 1'b1};
      ivnode[0] = node_t'(vals[8*b +: 4]);
      ivnode[1] = node_t'(vals[8*b + 4 +: 4]);
    end
    prev_beats = nbeats;
  endtask

  // ----------------------------------------
  // output monitor on enabled edges only
  // ----------------------------------------

  task automatic take_row();
    cnode_res_t got;
    if (exp_row_q.size() == 0 || eop_q.size() == 0) begin
      report_error("row result appeared with no row pending");
    end
    got.min1      = omin1;
    got.min2      = omin2;
    got.min1_idx  = omin1_idx;
    got.prod_sign = oprod_sign;
    got.vn_sign   = ovn_sign;
    got.vn_cnt    = ovn_cnt;
    check_row(got, exp_row_q.pop_front());
    check_delay(ena_cnt - eop_q.pop_front(), 3);
    rows_seen++;
  endtask

  task automatic take_msg_beat();
    if (exp_last_q.size() == 0) begin
      report_error("message beat appeared with no row pending");
    end
    for (int l = 0; l < `CNODE_LANES; l++) begin
      check_msg(omsg[l], exp_msg_q.pop_front(), beat_in_row * `CNODE_LANES + l);
    end
    check_last(omsg_last, exp_last_q.pop_front());
    beats_seen++;
    beat_in_row = omsg_last ? 0 : beat_in_row + 1;
  endtask

  always @(posedge iclk) begin
    if (!ireset && iclkena) begin
      ena_cnt++;
      if (ival && ieop) begin
        eop_q.push_back(ena_cnt);
      end
      if (orow_val) begin
        take_row();
      end
      if (omsg_val) begin
        take_msg_beat();
      end
    end
  end

  // hang guard
  always @(posedge iclk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYC) begin
      report_error($sformatf("timeout after %0d cycles, %0d of %0d rows seen",
        cycle_cnt, rows_seen, N_ROWS));
    end
  end

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial begin
    seed_val    = $urandom(94467);
    iclk        = 1'b0;
    ireset      = 1'b1;
    iclkena     = 1'b0;
    isop        = 1'b0;
    ival        = 1'b0;
    ieop        = 1'b0;
    imask       = '0;
    ivnode[0]   = '0;
    ivnode[1]   = '0;
    prev_beats  = 0;
    beats_exp   = 0;
    rows_seen   = 0;
    beats_seen  = 0;
    beat_in_row = 0;
    ena_cnt     = 0;
    cycle_cnt   = 0;

    // full rows with ties across beats and inside a lane pair
    tab[0]  = '{deg: 4'd8, stall: 4'b0000, gap: 1'b0, vals: 32'h35E27946};
    tab[1]  = '{deg: 4'd8, stall: 4'b0101, gap: 1'b0, vals: 32'h77711777};
    tab[2]  = '{deg: 4'd8, stall: 4'b0000, gap: 1'b0, vals: 32'h65432112};
    // short and odd rows with degree 1 back to back with degree 3
    tab[3]  = '{deg: 4'd1, stall: 4'b0000, gap: 1'b0, vals: 32'h00000005};
    tab[4]  = '{deg: 4'd3, stall: 4'b0010, gap: 1'b0, vals: 32'h00000F93};
    tab[5]  = '{deg: 4'd5, stall: 4'b0000, gap: 1'b1, vals: 32'h000C4D2E};
    // most negative input everywhere, then all zeros
    tab[6]  = '{deg: 4'd8, stall: 4'b0000, gap: 1'b0, vals: 32'h88888888};
    tab[7]  = '{deg: 4'd8, stall: 4'b0000, gap: 1'b0, vals: 32'h00000000};
    tab[8]  = '{deg: 4'd6, stall: 4'b1111, gap: 1'b0, vals: 32'h00807010};
    tab[9]  = '{deg: 4'd2, stall: 4'b0000, gap: 1'b1, vals: 32'h000000F1};
    tab[10] = '{deg: 4'd7, stall: 4'b0000, gap: 1'b0, vals: 32'h01234567};

    repeat (16) @(posedge iclk);
    @(negedge iclk);
    ireset  = 1'b0;
    iclkena = 1'b1;
    if (orow_val !== 1'b0 || omsg_val !== 1'b0) begin
      report_error("outputs not idle after reset");
    end
    repeat (3) @(negedge iclk);

    for (int r = 0; r < N_TAB; r++) begin
      drive_row(int'(tab[r].deg), tab[r].vals, tab[r].stall, tab[r].gap);
    end
    // random rows with at most one stall each
    for (int r = 0; r < N_RAND; r++) begin
      drive_row(1 + int'($urandom % 8), $urandom,
                ($urandom % 4 == 0) ? (4'b0001 << ($urandom % 4)) : 4'b0000,
                logic'($urandom % 2));
    end
    @(negedge iclk);
    iclkena = 1'b1;
    ival    = 1'b0;
    isop    = 1'b0;
    ieop    = 1'b0;

    wait (rows_seen == N_ROWS && beats_seen == beats_exp);
    if (exp_row_q.size() == 0 && exp_msg_q.size() == 0 && exp_last_q.size() == 0 &&
        eop_q.size() == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      report_error($sformatf("%0d message beats seen, %0d expected, results left over",
        beats_seen, beats_exp));
    end
  end

endmodule

// File: hw/cnode_unit.sv
// top level of the min-sum check node unit, pre-engine, min search and message generator in a row
`timescale 1ns/1ps
`include "cnode_unit_defines.svh"

module cnode_unit
  import cnode_unit_pkg::*;
(
  input  logic                      iclk,
  input  logic                      ireset,
  input  logic                      iclkena,
  // variable-to-check beats
  input  logic                      isop,
  input  logic                      ival,
  input  logic                      ieop,
  input  logic [`CNODE_LANES-1:0]   imask,
  input  node_t                     ivnode [`CNODE_LANES],
  // compressed row result
  output logic                      orow_val,
  output mag_t                      omin1,
  output mag_t                      omin2,
  output idx_t                      omin1_idx,
  output logic                      oprod_sign,
  output logic [`CNODE_MAX_DEG-1:0] ovn_sign,
  output cnt_t                      ovn_cnt,
  // check-to-variable messages
  output logic                      omsg_val,
  output msg_t                      omsg [`CNODE_LANES],
  output logic                      omsg_last
);

  // ----------------------------------------
  // internal links
  // ----------------------------------------

  cnode_beat_if beat_bus ();

  logic       res_val;
  cnode_res_t res;

  // ----------------------------------------
  // stages
  // ----------------------------------------

  cnode_pre_engine u_pre_engine (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .isop    (isop),
    .ival    (ival),
    .ieop    (ieop),
    .imask   (imask),
    .ivnode  (ivnode),
    .beat    (beat_bus.src)
  );

  cnode_min_search u_min_search (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .beat    (beat_bus.dst),
    .res_val (res_val),
    .res     (res)
  );

  cnode_msg_gen u_msg_gen (
    .iclk      (iclk),
    .ireset    (ireset),
    .iclkena   (iclkena),
    .res_val   (res_val),
    .res       (res),
    .omsg_val  (omsg_val),
    .omsg      (omsg),
    .omsg_last (omsg_last)
  );

  // result struct broken out to ports
  assign orow_val   = res_val;
  assign omin1      = res.min1;
  assign omin2      = res.min2;
  assign omin1_idx  = res.min1_idx;
  assign oprod_sign = res.prod_sign;
  assign ovn_sign   = res.vn_sign;
  assign ovn_cnt    = res.vn_cnt;

endmodule

// File: hw/cnode_msg_gen.sv
// expands a compressed row result into offset min-sum check-to-variable messages, two per beat
`timescale 1ns/1ps
`include "cnode_unit_defines.svh"

module cnode_msg_gen
  import cnode_unit_pkg::*;
(
  input  logic       iclk,
  input  logic       ireset,
  input  logic       iclkena,
  input  logic       res_val,
  input  cnode_res_t res,
  output logic       omsg_val,
  output msg_t       omsg [`CNODE_LANES],
  output logic       omsg_last
);

  localparam int BCNT_W = $clog2(`CNODE_MAX_BEATS);

  // emission state
  logic              busy;
  logic [BCNT_W-1:0] beat_cnt;
  cnode_res_t        res_q;

  // beats of the latched row and last-beat flag
  cnt_t              nbeats;
  logic              last;
  idx_t              lane_pos [`CNODE_LANES];

  // one outgoing message for input k of row r
  function automatic msg_t gen_msg(input cnode_res_t r, input idx_t k);
    mag_t mag;
    mag_t cor;
    msg_t m;
    // the min1 holder gets the second smallest
    mag = (k == r.min1_idx) ? r.min2 : r.min1;
    // offset correction, clipped at zero
    if (mag > mag_t'(`CNODE_OFFSET)) begin
      cor = mag - mag_t'(`CNODE_OFFSET);
    end else begin
      cor = '0;
    end
    m = msg_t'({1'b0, cor});
    // own sign removed from the row product
    if (r.prod_sign ^ r.vn_sign[k]) begin
      m = -m;
    end
    return m;
  endfunction

  // ----------------------------------------
  // beat sequencing
  // ----------------------------------------

  assign nbeats = (res_q.vn_cnt + cnt_t'(1)) >> 1;
  assign last   = (cnt_t'(beat_cnt) == nbeats - cnt_t'(1));

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      busy     <= 1'b0;
      beat_cnt <= '0;
    end else if (iclkena) begin
      if (res_val) begin
        // new row may start on the last beat of the previous one
        busy     <= 1'b1;
        beat_cnt <= '0;
      end else if (busy) begin
        if (last) begin
          busy <= 1'b0;
        end else begin
          beat_cnt <= beat_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena && res_val) begin
      res_q <= res;
    end
  end

  // ----------------------------------------
  // message lanes
  // ----------------------------------------

  always_comb begin
    for (int l = 0; l < `CNODE_LANES; l++) begin
      lane_pos[l] = idx_t'(int'(beat_cnt) * `CNODE_LANES + l);
    end
  end

  always_comb begin
    for (int l = 0; l < `CNODE_LANES; l++) begin
      // lanes past the row degree stay zero
      if (cnt_t'(lane_pos[l]) < res_q.vn_cnt) begin
        omsg[l] = gen_msg(res_q, lane_pos[l]);
      end else begin
        omsg[l] = '0;
      end
    end
  end

  assign omsg_val  = busy;
  assign omsg_last = busy & last;

  // upstream row spacing keeps results from overrunning the emission
  a_no_overrun : assert property (@(posedge iclk) disable iff (ireset)
    (iclkena && res_val && busy) |-> last)
    else $error("row result arrived during message emission");

endmodule

// File: hw/cnode_min_search.sv
// row-wide min-sum reduction of sorted beats into one compressed check node result
`timescale 1ns/1ps
`include "cnode_unit_defines.svh"

module cnode_min_search
  import cnode_unit_pkg::*;
(
  input  logic       iclk,
  input  logic       ireset,
  input  logic       iclkena,
  cnode_beat_if.dst  beat,
  output logic       res_val,
  output cnode_res_t res
);

  localparam int BCNT_W = $clog2(`CNODE_MAX_BEATS);

  // control
  logic                      row_open;
  logic [BCNT_W-1:0]         beat_cnt;

  // running accumulators of the open row
  mag_t                      acc_min1;
  mag_t                      acc_min2;
  idx_t                      acc_idx;
  logic                      acc_psign;
  logic [`CNODE_MAX_DEG-1:0] acc_vsign;
  cnt_t                      acc_cnt;

  // merge of the current beat into the accumulators
  logic [BCNT_W-1:0]         bidx;
  idx_t                      new_idx;
  cnt_t                      beat_used;
  mag_t                      nxt_min1;
  mag_t                      nxt_min2;
  idx_t                      nxt_idx;
  logic                      nxt_psign;
  logic [`CNODE_MAX_DEG-1:0] nxt_vsign;
  cnt_t                      nxt_cnt;

  // ----------------------------------------
  // beat position and used count
  // ----------------------------------------

  // sop restarts numbering even if the counter was left elsewhere
  assign bidx    = beat.sop ? '0 : beat_cnt;
  // row position = beat * 2 + lane
  assign new_idx = idx_t'({bidx, beat.lidx});
  // only the larger slot can hold an unused lane
  assign beat_used = (beat.lmax == MAG_UNUSED) ? cnt_t'(1) : cnt_t'(2);

  // ----------------------------------------
  // min1 / min2 merge
  // ----------------------------------------

  always_comb begin
    if (beat.sop) begin
      nxt_min1 = beat.lmin;
      nxt_min2 = beat.lmax;
      nxt_idx  = new_idx;
    end else if (beat.lmin < acc_min1) begin
      // new beat takes min1, old min1 competes with the pair's lmax
      nxt_min1 = beat.lmin;
      nxt_idx  = new_idx;
      nxt_min2 = (acc_min1 < beat.lmax) ? acc_min1 : beat.lmax;
    end else begin
      // equal magnitude keeps the earlier position
      nxt_min1 = acc_min1;
      nxt_idx  = acc_idx;
      nxt_min2 = (beat.lmin < acc_min2) ? beat.lmin : acc_min2;
    end
  end

  // sign vector, sign product and input count
  always_comb begin
    nxt_vsign = beat.sop ? '0 : acc_vsign;
    for (int l = 0; l < `CNODE_LANES; l++) begin
      nxt_vsign[int'(bidx)*`CNODE_LANES + l] = beat.sign[l];
    end
    nxt_psign = (beat.sop ? 1'b0 : acc_psign) ^ (^beat.sign);
    nxt_cnt   = (beat.sop ? cnt_t'(0) : acc_cnt) + beat_used;
  end

  // ----------------------------------------
  // registers
  // ----------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      row_open <= 1'b0;
      beat_cnt <= '0;
      res_val  <= 1'b0;
    end else if (iclkena) begin
      res_val <= beat.val & beat.eop;
      if (beat.val) begin
        row_open <= ~beat.eop;
        beat_cnt <= beat.eop ? '0 : bidx + 1'b1;
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena && beat.val) begin
      acc_min1  <= nxt_min1;
      acc_min2  <= nxt_min2;
      acc_idx   <= nxt_idx;
      acc_psign <= nxt_psign;
      acc_vsign <= nxt_vsign;
      acc_cnt   <= nxt_cnt;
      // result of the closing beat
      if (beat.eop) begin
        res.min1      <= nxt_min1;
        res.min2      <= nxt_min2;
        res.min1_idx  <= nxt_idx;
        res.prod_sign <= nxt_psign;
        res.vn_sign   <= nxt_vsign;
        res.vn_cnt    <= nxt_cnt;
      end
    end
  end

  // row framing as seen two stages after the input
  a_no_nested_sop : assert property (@(posedge iclk) disable iff (ireset)
    (iclkena && beat.val && row_open) |-> !beat.sop)
    else $error("sop inside an open row");

  a_no_orphan_beat : assert property (@(posedge iclk) disable iff (ireset)
    (iclkena && beat.val && !row_open) |-> beat.sop)
    else $error("beat outside of a row");

endmodule

// File: hw/cnode_pre_engine.sv
// two-stage front end that splits sign and magnitude and then sorts the lane pair
`timescale 1ns/1ps
`include "cnode_unit_defines.svh"

module cnode_pre_engine
  import cnode_unit_pkg::*;
(
  input  logic                    iclk,
  input  logic                    ireset,
  input  logic                    iclkena,
  input  logic                    isop,
  input  logic                    ival,
  input  logic                    ieop,
  input  logic [`CNODE_LANES-1:0] imask,
  input  node_t                   ivnode [`CNODE_LANES],
  cnode_beat_if.src               beat
);

  // stage one registers
  logic                    val1;
  logic                    sop1;
  logic                    eop1;
  logic [`CNODE_LANES-1:0] sign1;
  mag_t                    mag1 [`CNODE_LANES];

  // lane 1 strictly smaller so ties stay on lane 0
  logic                    lane_swap;

  // two's complement magnitude where -8 maps to 8
  function automatic mag_t abs_mag(input node_t v);
    logic s;
    s = v[`CNODE_NODE_W-1];
    return mag_t'(v ^ {`CNODE_NODE_W{s}}) + mag_t'(s);
  endfunction

  // ----------------------------------------
  // stage one splits sign and magnitude
  // ----------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val1 <= 1'b0;
    end else if (iclkena) begin
      val1 <= ival;
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena && ival) begin
      sop1 <= isop;
      eop1 <= ieop;
      for (int l = 0; l < `CNODE_LANES; l++) begin
        // unused lane never wins a minimum and leaves the sign product alone
        if (imask[l]) begin
          sign1[l] <= ivnode[l][`CNODE_NODE_W-1];
          mag1[l]  <= abs_mag(ivnode[l]);
        end else begin
          sign1[l] <= 1'b0;
          mag1[l]  <= MAG_UNUSED;
        end
      end
    end
  end

  // ----------------------------------------
  // stage two sorts the lane pair
  // ----------------------------------------

  assign lane_swap = (mag1[1] < mag1[0]);

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      beat.val <= 1'b0;
    end else if (iclkena) begin
      beat.val <= val1;
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena && val1) begin
      beat.sop  <= sop1;
      beat.eop  <= eop1;
      beat.sign <= sign1;
      beat.lmin <= lane_swap ? mag1[1] : mag1[0];
      beat.lmax <= lane_swap ? mag1[0] : mag1[1];
      beat.lidx <= lane_swap;
    end
  end

  // a beat must carry at least one real input
  a_lane_used : assert property (@(posedge iclk) disable iff (ireset)
    (iclkena && ival) |-> (|imask))
    else $error("input beat with no used lane");

endmodule

// File: hw/cnode_beat_if.sv
// one pre-processed beat, driven by the pre-engine and consumed by the min search
`timescale 1ns/1ps
`include "cnode_unit_defines.svh"

interface cnode_beat_if
  import cnode_unit_pkg::*;
();

  // ----------------------------------------
  // framing
  // ----------------------------------------

  logic sop;
  logic val;
  logic eop;

  // ----------------------------------------
  // payload
  // ----------------------------------------

  // sign per lane, unused lanes carry 0
  logic [`CNODE_LANES-1:0] sign;
  // sorted magnitudes of the lane pair
  mag_t                    lmin;
  mag_t                    lmax;
  // lane holding lmin
  logic                    lidx;

  // pre-engine side
  modport src (output sop, val, eop, sign, lmin, lmax, lidx);

  // search engine side
  modport dst (input sop, val, eop, sign, lmin, lmax, lidx);

endinterface

// File: hw/cnode_unit_pkg.sv
// types shared by the check node stages and the testbench, imported by wildcard where used
`include "cnode_unit_defines.svh"

package cnode_unit_pkg;

  // ----------------------------------------
  // scalar types
  // ----------------------------------------

  // signed input value from the variable nodes
  typedef logic signed [`CNODE_NODE_W-1:0] node_t;

  // unsigned magnitude, same width so that |-8| = 8 still fits
  typedef logic [`CNODE_NODE_W-1:0] mag_t;

  // outgoing check-to-variable message, one bit wider than the input
  typedef logic signed [`CNODE_NODE_W:0] msg_t;

  // position of an input inside a row
  typedef logic [$clog2(`CNODE_MAX_DEG)-1:0] idx_t;

  // number of inputs of a row, 1 .. CNODE_MAX_DEG
  typedef logic [$clog2(`CNODE_MAX_DEG+1)-1:0] cnt_t;

  // magnitude code of an unused lane
  // real inputs top out at 2**(W-1), so all ones never comes from data
  localparam mag_t MAG_UNUSED = '1;

  // ----------------------------------------
  // compressed row result
  // ----------------------------------------

  typedef struct packed {
    mag_t                     min1;       // smallest magnitude
    mag_t                     min2;       // second smallest
    idx_t                     min1_idx;   // where min1 sits
    logic                     prod_sign;  // xor of all input signs
    logic [`CNODE_MAX_DEG-1:0] vn_sign;   // input k at bit k
    cnt_t                     vn_cnt;     // used inputs of the row
  } cnode_res_t;

endpackage

// File: hw/cnode_unit_defines.svh
// size constants of the check node unit, included by the package, the RTL stages and the testbench
`ifndef CNODE_UNIT_DEFINES_SVH
`define CNODE_UNIT_DEFINES_SVH

// ----------------------------------------
// datapath geometry
// ----------------------------------------

// inputs per beat as the pre-engine pair sort needs exactly two
`define CNODE_LANES 2

// width of one signed variable-to-check value
`define CNODE_NODE_W 4

// largest row degree of the parity matrix
`define CNODE_MAX_DEG 8

// beats of the longest row
`define CNODE_MAX_BEATS (`CNODE_MAX_DEG / `CNODE_LANES)

// ----------------------------------------
// min-sum correction
// ----------------------------------------

// offset subtracted from every outgoing magnitude
`define CNODE_OFFSET 1

`endif
